//--- tiled_cmd.f
+incdir+.
tiled_cmd_pkg.sv
cmd_encod_tiled_rd.sv
cmd_encod_tiled_wr.sv
cmd_encod_tiled_rw.sv
cmd_seq_buf.sv
cmd_seq_player.sv
tiled_cmd_top.sv
tb_clk_gen.sv
tb_tiled_cmd.sv

//--- Makefile
# Verilator flow for the tiled command encoder

VERILATOR ?= verilator
FILELIST  ?= tiled_cmd.f
TB_TOP    ?= tb_tiled_cmd
RTL_TOP   ?= tiled_cmd_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Result: PASSED
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_tiled_cmd.sv
//////////////////////////////////////////////////////////////////////
// tiled command encoder testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tiled_cmd_consts.svh"

module tb_tiled_cmd;
    localparam int W_ENC_DONE = 0;
    localparam int W_SEQ_DONE = 1;
    localparam int W_OVERFLOW = 2;
    localparam int W_RST_DONE = 3;

    logic clk;
    logic rst;
    tiled_cmd_pkg::bank_t       start_bank;
    tiled_cmd_pkg::row_addr_t   start_row;
    tiled_cmd_pkg::col_burst_t  start_col;
    tiled_cmd_pkg::rowcol_inc_t rowcol_inc_in;
    tiled_cmd_pkg::tile_cnt_t   num_rows_in_m1;
    tiled_cmd_pkg::tile_cnt_t   num_cols_in_m1;
    logic keep_open_in;
    logic skip_next_page_in;
    logic start_rd;
    logic start_wr;
    logic start;
    logic encode_done;
    logic ddr_cmd_valid;
    tiled_cmd_pkg::cmd_type_t   ddr_cmd_type;
    tiled_cmd_pkg::bank_t       ddr_bank;
    tiled_cmd_pkg::cmd_addr_t   ddr_addr;
    logic seq_done;
    logic overflow;

    integer      seed;
    logic [31:0] exp_q[$];                 // model words, issue order
    int          errors;
    int          timeouts;
    int          n_compared;
    int          since_issue;              // cycles since last issue
    int          enc_done_cnt;
    tiled_cmd_pkg::pause_t last_pause;     // model pause of previous command
    logic        started_any;
    logic        check_order;              // off once words get dropped
    logic        ovf_allowed;
    logic        enc_done_pending;         // encode_done seen, seq_done not yet

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    tiled_cmd_top dut_i (
        .clk(clk), .rst(rst),
        .start_bank(start_bank), .start_row(start_row), .start_col(start_col),
        .rowcol_inc_in(rowcol_inc_in),
        .num_rows_in_m1(num_rows_in_m1), .num_cols_in_m1(num_cols_in_m1),
        .keep_open_in(keep_open_in), .skip_next_page_in(skip_next_page_in),
        .start_rd(start_rd), .start_wr(start_wr),
        .start(start), .encode_done(encode_done), .ddr_cmd_valid(ddr_cmd_valid),
        .ddr_cmd_type(ddr_cmd_type), .ddr_bank(ddr_bank), .ddr_addr(ddr_addr),
        .seq_done(seq_done), .overflow(overflow)
    );

    task automatic report_check_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    assert property (@(posedge clk) !started_any |->
            !(start || encode_done || ddr_cmd_valid || seq_done || overflow))
        else report_check_failure("output high before any start request");
    assert property (@(posedge clk) disable iff (rst) start == $past(start_rd || start_wr))
        else report_check_failure("start not one cycle after the start request");
    assert property (@(posedge clk) disable iff (rst) overflow |=> overflow)
        else report_check_failure("overflow cleared without reset");
    assert property (@(posedge clk) !ovf_allowed |-> !overflow)
        else report_check_failure("overflow on a tile that fits the buffer");
    assert property (@(posedge clk) seq_done |-> ddr_cmd_valid)
        else report_check_failure("seq_done without a command issue");

    task automatic add_expected(input tiled_cmd_pkg::cmd_type_t ty,
            input tiled_cmd_pkg::bank_t bk, input tiled_cmd_pkg::cmd_addr_t addr,
            input tiled_cmd_pkg::pause_t pause);
        exp_q.push_back({ty, bk, addr, 1'b0, pause});
    endtask

    // expected command list from the tile rules
    task automatic build_expected(input logic is_wr, input logic keep, input logic skip,
            input tiled_cmd_pkg::bank_t bk, input tiled_cmd_pkg::rowcol_t base,
            input tiled_cmd_pkg::rowcol_inc_t inc,
            input tiled_cmd_pkg::tile_cnt_t rows_m1, input tiled_cmd_pkg::tile_cnt_t cols_m1);
        tiled_cmd_pkg::rowcol_t    rc;
        tiled_cmd_pkg::col_burst_t colb;
        tiled_cmd_pkg::cmd_type_t  data_type;
        tiled_cmd_pkg::pause_t     p;
        logic [31:0]               w;
        exp_q.delete();
        data_type = is_wr ? tiled_cmd_pkg::write : tiled_cmd_pkg::read;
        if (!skip) add_expected(tiled_cmd_pkg::buf_rst, bk, '0, '0);
        for (int r = 0; r <= int'(rows_m1); r++) begin
            rc = base + tiled_cmd_pkg::rowcol_t'(r) * tiled_cmd_pkg::rowcol_t'(inc);
            add_expected(tiled_cmd_pkg::activate, bk, rc[21:7], `TILED_TRCD);
            for (int c = 0; c <= int'(cols_m1); c++) begin
                colb = rc[6:0] + 7'(c);
                p    = (is_wr && !keep && c == int'(cols_m1)) ? `TILED_TWR : '0;
                add_expected(data_type, bk, tiled_cmd_pkg::cmd_addr_t'({colb, 3'b000}), p);
            end
            if (!keep) add_expected(tiled_cmd_pkg::precharge, bk, '0, `TILED_TRP);
        end
        w = exp_q.pop_back();
        w[`TILED_CMD_DONE_BIT] = 1'b1;              // done on the last command
        exp_q.push_back(w);
    endtask

    function automatic logic watched_level(input int sel);
        case (sel)
            W_ENC_DONE: return encode_done;
            W_SEQ_DONE: return seq_done;
            W_OVERFLOW: return overflow;
            default:    return !rst;
        endcase
    endfunction

    // poll on falling edges, outputs settled
    task automatic wait_for_level(input int sel, input string what, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!watched_level(sel) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!watched_level(sel)) begin
            timeouts++;
            $display("timeout at %0t ns: %s never arrived", $time, what);
        end
    endtask

    task automatic prepare_and_start(input logic is_wr, input logic keep, input logic skip,
            input tiled_cmd_pkg::tile_cnt_t rows_m1, input tiled_cmd_pkg::tile_cnt_t cols_m1);
        tiled_cmd_pkg::bank_t       bk;
        tiled_cmd_pkg::row_addr_t   row;
        tiled_cmd_pkg::col_burst_t  col;
        tiled_cmd_pkg::rowcol_inc_t inc;
        bk  = 3'($random(seed));
        row = 15'($random(seed));
        col = 7'($random(seed));
        inc = 14'($random(seed));
        build_expected(is_wr, keep, skip, bk, {row, col}, inc, rows_m1, cols_m1);
        @(posedge clk);
        start_bank        <= bk;
        start_row         <= row;
        start_col         <= col;
        rowcol_inc_in     <= inc;
        num_rows_in_m1    <= rows_m1;
        num_cols_in_m1    <= cols_m1;
        keep_open_in      <= keep;
        skip_next_page_in <= skip;
        start_rd          <= !is_wr;
        start_wr          <= is_wr;
        started_any       <= 1'b1;
        @(posedge clk);
        start_rd <= 1'b0;                     // one-cycle request
        start_wr <= 1'b0;
    endtask

    task automatic run_tile(input logic is_wr, input logic keep, input logic skip);
        int done_before;
        done_before = enc_done_cnt;
        prepare_and_start(is_wr, keep, skip, 6'($random(seed) & 3), 6'($random(seed) & 3));
        wait_for_level(W_ENC_DONE, "encode_done", 100);
        wait_for_level(W_SEQ_DONE, "seq_done", 300);
        @(posedge clk);                       // monitor has taken the last issue
        assert (exp_q.size() == 0)
            else report_check_failure($sformatf("%0d commands never issued", exp_q.size()));
        assert (enc_done_cnt == done_before + 1)
            else report_check_failure("encode_done count per sequence is not one");
    endtask

    // issue monitor, compares against the model head
    always @(negedge clk) begin
        logic [31:0] exp_word;
        if (!rst) begin
            since_issue++;
            if (seq_done) begin
                assert (enc_done_pending) else report_check_failure("seq_done before encode_done");
                enc_done_pending = 1'b0;
            end
            if (encode_done) begin
                assert (!enc_done_pending) else report_check_failure("encode_done twice");
                enc_done_pending = 1'b1;
                enc_done_cnt++;
            end
            if (ddr_cmd_valid && check_order) begin
                if (exp_q.size() == 0) begin
                    report_check_failure("command issued past the end of the sequence");
                end else begin
                    exp_word = exp_q.pop_front();
                    assert (ddr_cmd_type == tiled_cmd_pkg::cmd_type_t'(exp_word[31:29]) &&
                            ddr_bank == exp_word[28:26] && ddr_addr == exp_word[25:11])
                        else report_check_failure($sformatf(
                            "cmd %0d got type %0d bank %0d addr %h, expected %0d %0d %h",
                            n_compared, ddr_cmd_type, ddr_bank, ddr_addr,
                            exp_word[31:29], exp_word[28:26], exp_word[25:11]));
                    assert (seq_done == exp_word[`TILED_CMD_DONE_BIT])
                        else report_check_failure($sformatf("cmd %0d seq_done %0b", n_compared,
                                                            seq_done));
                    assert (since_issue >= int'(last_pause) + 1)
                        else report_check_failure($sformatf("gap %0d after pause %0d",
                                                            since_issue, last_pause));
                    last_pause = exp_word[`TILED_CMD_PAUSE_BITS-1:0];
                    n_compared++;
                end
            end
            if (ddr_cmd_valid) since_issue = 0;
        end
    end

    initial begin
        seed              = 32'hea73_f6a2;
        errors            = 0;
        timeouts          = 0;
        n_compared        = 0;
        since_issue       = 1000;              // no earlier command
        enc_done_cnt      = 0;
        last_pause        = '0;
        enc_done_pending  = 1'b0;
        started_any       = 1'b0;
        check_order       = 1'b1;
        ovf_allowed       = 1'b0;
        start_bank        = '0;
        start_row         = '0;
        start_col         = '0;
        rowcol_inc_in     = '0;
        num_rows_in_m1    = '0;
        num_cols_in_m1    = '0;
        keep_open_in      = 1'b0;
        skip_next_page_in = 1'b0;
        start_rd          = 1'b0;
        start_wr          = 1'b0;
        wait_for_level(W_RST_DONE, "reset release", 20);
        repeat (4) @(posedge clk);             // quiet outputs before any request
        run_tile(1'b0, 1'b0, 1'b0);            // read, buf_rst and precharge
        run_tile(1'b0, 1'b0, 1'b0);
        run_tile(1'b1, 1'b1, 1'b1);            // write, page kept open
        run_tile(1'b0, 1'b1, 1'b1);            // selection back to read
        run_tile(1'b1, 1'b0, 1'b0);            // write recovery before precharge
        check_order = 1'b0;                    // words get dropped from here on
        ovf_allowed = 1'b1;
        prepare_and_start(1'b0, 1'b0, 1'b0, 6'd63, 6'd0);
        wait_for_level(W_OVERFLOW, "overflow", 400);
        wait_for_level(W_ENC_DONE, "encode_done of the long tile", 400);
        @(negedge clk);
        assert (overflow) else report_check_failure("overflow not held after the long tile");
        $display("summary: %0d errors, %0d timeouts, %0d commands compared",
                 errors, timeouts, n_compared);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        rst = 1'b1;                            // async reset from time 0
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                           // release on a rising edge
    end

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

//--- tiled_cmd_top.sv
//////////////////////////////////////////////////////////////////////
// tiled command encoder top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tiled_cmd_top (
    input  logic                       clk,
    input  logic                       rst,
    input  tiled_cmd_pkg::bank_t       start_bank,
    input  tiled_cmd_pkg::row_addr_t   start_row,
    input  tiled_cmd_pkg::col_burst_t  start_col,
    input  tiled_cmd_pkg::rowcol_inc_t rowcol_inc_in,
    input  tiled_cmd_pkg::tile_cnt_t   num_rows_in_m1,
    input  tiled_cmd_pkg::tile_cnt_t   num_cols_in_m1,
    input  logic                       keep_open_in,
    input  logic                       skip_next_page_in,
    input  logic                       start_rd,
    input  logic                       start_wr,
    output logic                       start,
    output logic                       encode_done,
    output logic                       ddr_cmd_valid,
    output tiled_cmd_pkg::cmd_type_t   ddr_cmd_type,
    output tiled_cmd_pkg::bank_t       ddr_bank,
    output tiled_cmd_pkg::cmd_addr_t   ddr_addr,
    output logic                       seq_done,
    output logic                       overflow
);
    tiled_cmd_pkg::cmd_word_t enc_cmd;   // encoder to buffer
    tiled_cmd_pkg::cmd_word_t rd_data;   // buffer head to player
    logic                     enc_wr;
    logic                     empty;
    logic                     pop;

    cmd_encod_tiled_rw cmd_encod_tiled_rw_i (
        .rst(rst), .clk(clk),
        .start_bank(start_bank), .start_row(start_row), .start_col(start_col),
        .rowcol_inc_in(rowcol_inc_in),
        .num_rows_in_m1(num_rows_in_m1), .num_cols_in_m1(num_cols_in_m1),
        .keep_open_in(keep_open_in), .skip_next_page_in(skip_next_page_in),
        .start_rd(start_rd), .start_wr(start_wr),
        .start(start), .enc_cmd(enc_cmd), .enc_wr(enc_wr), .enc_done(encode_done)
    );

    cmd_seq_buf cmd_seq_buf_i (
        .clk(clk), .rst(rst),
        .push(enc_wr), .push_data(enc_cmd), .pop(pop),
        .rd_data(rd_data), .empty(empty), .overflow(overflow)
    );

    cmd_seq_player cmd_seq_player_i (
        .clk(clk), .rst(rst),
        .rd_data(rd_data), .empty(empty), .pop(pop),
        .ddr_cmd_valid(ddr_cmd_valid), .ddr_cmd_type(ddr_cmd_type),
        .ddr_bank(ddr_bank), .ddr_addr(ddr_addr), .seq_done(seq_done)
    );

endmodule

//--- cmd_seq_player.sv
//////////////////////////////////////////////////////////////////////
// command sequence player
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tiled_cmd_consts.svh"

module cmd_seq_player (
    input  logic                     clk,
    input  logic                     rst,
    input  tiled_cmd_pkg::cmd_word_t rd_data,
    input  logic                     empty,
    output logic                     pop,
    output logic                     ddr_cmd_valid,
    output tiled_cmd_pkg::cmd_type_t ddr_cmd_type,
    output tiled_cmd_pkg::bank_t     ddr_bank,
    output tiled_cmd_pkg::cmd_addr_t ddr_addr,
    output logic                     seq_done
);
    tiled_cmd_pkg::pause_t pause_cnt;  // cycles left before next issue
    logic                  issue;

    assign issue         = !empty && pause_cnt == '0;
    assign pop           = issue;          // head leaves with the issue
    assign ddr_cmd_valid = issue;
    assign ddr_cmd_type  = tiled_cmd_pkg::cmd_type_t'(rd_data[31:29]);
    assign ddr_bank      = rd_data[28:26];
    assign ddr_addr      = rd_data[`TILED_CMD_DONE_BIT+1 +: `TILED_ADDRESS_NUMBER];
    assign seq_done      = issue && rd_data[`TILED_CMD_DONE_BIT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pause_cnt <= '0;
        end else if (issue) begin
            pause_cnt <= rd_data[`TILED_CMD_PAUSE_BITS-1:0]; // next issue pause+1 later
        end else if (pause_cnt != '0) begin
            pause_cnt <= pause_cnt - 1'b1;
        end
    end

endmodule

//--- cmd_seq_buf.sv
//////////////////////////////////////////////////////////////////////
// command sequence buffer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tiled_cmd_consts.svh"

module cmd_seq_buf (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  tiled_cmd_pkg::cmd_word_t push_data,
    input  logic                     pop,
    output tiled_cmd_pkg::cmd_word_t rd_data,   // head word
    output logic                     empty,
    output logic                     overflow   // sticky until reset
);
    localparam int DEPTH = 1 << `TILED_SEQ_DEPTH_LOG2;

    tiled_cmd_pkg::cmd_word_t           mem [0:DEPTH-1];
    logic [`TILED_SEQ_DEPTH_LOG2-1:0]   wr_ptr;
    logic [`TILED_SEQ_DEPTH_LOG2-1:0]   rd_ptr;
    logic [`TILED_SEQ_DEPTH_LOG2:0]     count;     // 0..DEPTH
    logic                               full;
    logic                               do_push;
    logic                               do_pop;

    assign full    = count[`TILED_SEQ_DEPTH_LOG2]; // only set at DEPTH
    assign empty   = count == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
            if (push && full) overflow <= 1'b1; // word lost
        end
    end

endmodule

//--- cmd_encod_tiled_rw.sv
//////////////////////////////////////////////////////////////////////
// tiled read/write encoder selector
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cmd_encod_tiled_rw (
    input  logic                       rst,
    input  logic                       clk,
    input  tiled_cmd_pkg::bank_t       start_bank,
    input  tiled_cmd_pkg::row_addr_t   start_row,
    input  tiled_cmd_pkg::col_burst_t  start_col,
    input  tiled_cmd_pkg::rowcol_inc_t rowcol_inc_in,
    input  tiled_cmd_pkg::tile_cnt_t   num_rows_in_m1,
    input  tiled_cmd_pkg::tile_cnt_t   num_cols_in_m1,
    input  logic                       keep_open_in,
    input  logic                       skip_next_page_in,
    input  logic                       start_rd,
    input  logic                       start_wr,
    output logic                       start,     // either channel started
    output tiled_cmd_pkg::cmd_word_t   enc_cmd,
    output logic                       enc_wr,
    output logic                       enc_done
);
    tiled_cmd_pkg::cmd_word_t enc_cmd_rd;
    tiled_cmd_pkg::cmd_word_t enc_cmd_wr;
    logic                     enc_wr_rd;
    logic                     enc_wr_wr;
    logic                     enc_done_rd;
    logic                     enc_done_wr;
    logic                     select_wr;    // last started channel, read wins a tie

    cmd_encod_tiled_rd cmd_encod_tiled_rd_i (
        .rst(rst), .clk(clk),
        .start_bank(start_bank), .start_row(start_row), .start_col(start_col),
        .rowcol_inc_in(rowcol_inc_in),
        .num_rows_in_m1(num_rows_in_m1), .num_cols_in_m1(num_cols_in_m1),
        .keep_open_in(keep_open_in), .skip_next_page_in(skip_next_page_in),
        .start(start_rd),
        .enc_cmd(enc_cmd_rd), .enc_wr(enc_wr_rd), .enc_done(enc_done_rd)
    );

    cmd_encod_tiled_wr cmd_encod_tiled_wr_i (
        .rst(rst), .clk(clk),
        .start_bank(start_bank), .start_row(start_row), .start_col(start_col),
        .rowcol_inc_in(rowcol_inc_in),
        .num_rows_in_m1(num_rows_in_m1), .num_cols_in_m1(num_cols_in_m1),
        .keep_open_in(keep_open_in), .skip_next_page_in(skip_next_page_in),
        .start(start_wr),
        .enc_cmd(enc_cmd_wr), .enc_wr(enc_wr_wr), .enc_done(enc_done_wr)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start     <= 1'b0;
            select_wr <= 1'b0;
            enc_wr    <= 1'b0;
            enc_done  <= 1'b0;
        end else begin
            start <= start_rd || start_wr;
            if (start_rd) select_wr <= 1'b0;
            else if (start_wr) select_wr <= 1'b1;
            enc_wr   <= select_wr ? enc_wr_wr : enc_wr_rd;
            enc_done <= select_wr ? enc_done_wr : enc_done_rd;
        end
    end

    always_ff @(posedge clk) begin
        enc_cmd <= select_wr ? enc_cmd_wr : enc_cmd_rd; // payload, qualified by enc_wr
    end

endmodule

//--- cmd_encod_tiled_wr.sv
//////////////////////////////////////////////////////////////////////
// tiled write command encoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tiled_cmd_consts.svh"

module cmd_encod_tiled_wr (
    input  logic                      rst,
    input  logic                      clk,
    input  tiled_cmd_pkg::bank_t      start_bank,
    input  tiled_cmd_pkg::row_addr_t  start_row,
    input  tiled_cmd_pkg::col_burst_t start_col,
    input  tiled_cmd_pkg::rowcol_inc_t rowcol_inc_in,  // row to row step, {row,col}
    input  tiled_cmd_pkg::tile_cnt_t  num_rows_in_m1,
    input  tiled_cmd_pkg::tile_cnt_t  num_cols_in_m1,
    input  logic                      keep_open_in,      // no precharge after a row
    input  logic                      skip_next_page_in, // no buffer reset first
    input  logic                      start,
    output tiled_cmd_pkg::cmd_word_t  enc_cmd,
    output logic                      enc_wr,
    output logic                      enc_done
);
    localparam int COL_W = `TILED_COLADDR_NUMBER - 3;

    typedef enum logic [2:0] {idle, buf_rst, activate, burst, precharge} state_t;

    state_t                      state;
    tiled_cmd_pkg::bank_t        bank;
    tiled_cmd_pkg::rowcol_t      rowcol;       // start of current tile row
    tiled_cmd_pkg::rowcol_inc_t  rowcol_inc;
    tiled_cmd_pkg::tile_cnt_t    num_cols_m1;
    tiled_cmd_pkg::tile_cnt_t    rows_left;
    tiled_cmd_pkg::tile_cnt_t    col_cnt;
    logic                        keep_open;
    logic                        last_col;
    logic                        row_end;
    logic                        last_cmd;
    tiled_cmd_pkg::col_burst_t   col_burst;
    tiled_cmd_pkg::cmd_type_t    cmd_type;
    tiled_cmd_pkg::cmd_addr_t    cmd_addr;
    tiled_cmd_pkg::pause_t       cmd_pause;

    assign last_col  = col_cnt == num_cols_m1;
    assign row_end   = (state == burst && last_col && keep_open) || state == precharge;
    assign last_cmd  = row_end && rows_left == '0;
    assign col_burst = rowcol[COL_W-1:0] + tiled_cmd_pkg::col_burst_t'(col_cnt);

    always_comb begin
        cmd_type  = tiled_cmd_pkg::nop;
        cmd_addr  = '0;
        cmd_pause = '0;
        case (state)
            buf_rst:   cmd_type = tiled_cmd_pkg::buf_rst;
            activate: begin
                cmd_type  = tiled_cmd_pkg::activate;
                cmd_addr  = rowcol[COL_W +: `TILED_ADDRESS_NUMBER];
                cmd_pause = `TILED_TRCD;
            end
            burst: begin
                cmd_type = tiled_cmd_pkg::write;
                cmd_addr = tiled_cmd_pkg::cmd_addr_t'({col_burst, 3'b000});
                if (last_col && !keep_open)
                    cmd_pause = `TILED_TWR; // write recovery before precharge
            end
            precharge: begin
                cmd_type  = tiled_cmd_pkg::precharge;
                cmd_pause = `TILED_TRP;
            end
            default:   cmd_type = tiled_cmd_pkg::nop;
        endcase
    end

    assign enc_wr  = state != idle;
    assign enc_cmd = {cmd_type, bank, cmd_addr, last_cmd, cmd_pause};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            enc_done  <= 1'b0;
            rows_left <= '0;
            col_cnt   <= '0;
        end else begin
            enc_done <= enc_wr && last_cmd;
            if (state == activate) col_cnt <= '0;
            else if (state == burst) col_cnt <= col_cnt + 1'b1;
            if (state == idle && start) rows_left <= num_rows_in_m1;
            else if (row_end && !last_cmd) rows_left <= rows_left - 1'b1;
            case (state)
                idle:      if (start) state <= skip_next_page_in ? activate : buf_rst;
                buf_rst:   state <= activate;
                activate:  state <= burst;
                burst: begin
                    if (last_col) begin
                        if (!keep_open) state <= precharge;
                        else if (last_cmd) state <= idle;
                        else state <= activate;
                    end
                end
                precharge: state <= last_cmd ? idle : activate;
                default:   state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            bank        <= start_bank;
            rowcol      <= {start_row, start_col};
            rowcol_inc  <= rowcol_inc_in;
            num_cols_m1 <= num_cols_in_m1;
            keep_open   <= keep_open_in;
        end else if (row_end && !last_cmd) begin
            rowcol <= rowcol + tiled_cmd_pkg::rowcol_t'(rowcol_inc);
        end
    end

endmodule

//--- cmd_encod_tiled_rd.sv
//////////////////////////////////////////////////////////////////////
// tiled read command encoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "tiled_cmd_consts.svh"

module cmd_encod_tiled_rd (
    input  logic                      rst,
    input  logic                      clk,
    input  tiled_cmd_pkg::bank_t      start_bank,
    input  tiled_cmd_pkg::row_addr_t  start_row,
    input  tiled_cmd_pkg::col_burst_t start_col,
    input  tiled_cmd_pkg::rowcol_inc_t rowcol_inc_in,  // row to row step, {row,col}
    input  tiled_cmd_pkg::tile_cnt_t  num_rows_in_m1,
    input  tiled_cmd_pkg::tile_cnt_t  num_cols_in_m1,
    input  logic                      keep_open_in,      // no precharge after a row
    input  logic                      skip_next_page_in, // no buffer reset first
    input  logic                      start,
    output tiled_cmd_pkg::cmd_word_t  enc_cmd,
    output logic                      enc_wr,
    output logic                      enc_done
);
    localparam int COL_W = `TILED_COLADDR_NUMBER - 3;

    typedef enum logic [2:0] {idle, buf_rst, activate, burst, precharge} state_t;

    state_t                      state;
    tiled_cmd_pkg::bank_t        bank;
    tiled_cmd_pkg::rowcol_t      rowcol;       // start of current tile row
    tiled_cmd_pkg::rowcol_inc_t  rowcol_inc;
    tiled_cmd_pkg::tile_cnt_t    num_cols_m1;
    tiled_cmd_pkg::tile_cnt_t    rows_left;
    tiled_cmd_pkg::tile_cnt_t    col_cnt;
    logic                        keep_open;
    logic                        last_col;
    logic                        row_end;      // last command of a row
    logic                        last_cmd;
    tiled_cmd_pkg::col_burst_t   col_burst;
    tiled_cmd_pkg::cmd_type_t    cmd_type;
    tiled_cmd_pkg::cmd_addr_t    cmd_addr;
    tiled_cmd_pkg::pause_t       cmd_pause;

    assign last_col  = col_cnt == num_cols_m1;
    assign row_end   = (state == burst && last_col && keep_open) || state == precharge;
    assign last_cmd  = row_end && rows_left == '0;
    assign col_burst = rowcol[COL_W-1:0] + tiled_cmd_pkg::col_burst_t'(col_cnt);

    always_comb begin
        cmd_type  = tiled_cmd_pkg::nop;
        cmd_addr  = '0;
        cmd_pause = '0;
        case (state)
            buf_rst:   cmd_type = tiled_cmd_pkg::buf_rst;
            activate: begin
                cmd_type  = tiled_cmd_pkg::activate;
                cmd_addr  = rowcol[COL_W +: `TILED_ADDRESS_NUMBER]; // row
                cmd_pause = `TILED_TRCD;
            end
            burst: begin
                cmd_type = tiled_cmd_pkg::read;
                cmd_addr = tiled_cmd_pkg::cmd_addr_t'({col_burst, 3'b000}); // column in words
            end
            precharge: begin
                cmd_type  = tiled_cmd_pkg::precharge;
                cmd_pause = `TILED_TRP;
            end
            default:   cmd_type = tiled_cmd_pkg::nop;
        endcase
    end

    assign enc_wr  = state != idle;
    assign enc_cmd = {cmd_type, bank, cmd_addr, last_cmd, cmd_pause};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            enc_done  <= 1'b0;
            rows_left <= '0;
            col_cnt   <= '0;
        end else begin
            enc_done <= enc_wr && last_cmd;
            if (state == activate) col_cnt <= '0;
            else if (state == burst) col_cnt <= col_cnt + 1'b1;
            if (state == idle && start) rows_left <= num_rows_in_m1;
            else if (row_end && !last_cmd) rows_left <= rows_left - 1'b1;
            case (state)
                idle:      if (start) state <= skip_next_page_in ? activate : buf_rst;
                buf_rst:   state <= activate;
                activate:  state <= burst;
                burst: begin
                    if (last_col) begin
                        if (!keep_open) state <= precharge;
                        else if (last_cmd) state <= idle;
                        else state <= activate;
                    end
                end
                precharge: state <= last_cmd ? idle : activate;
                default:   state <= idle;
            endcase
        end
    end

    // tile parameters, latched while idle
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            bank        <= start_bank;
            rowcol      <= {start_row, start_col};
            rowcol_inc  <= rowcol_inc_in;
            num_cols_m1 <= num_cols_in_m1;
            keep_open   <= keep_open_in;
        end else if (row_end && !last_cmd) begin
            rowcol <= rowcol + tiled_cmd_pkg::rowcol_t'(rowcol_inc); // next tile row
        end
    end

endmodule

//--- tiled_cmd_pkg.sv
//////////////////////////////////////////////////////////////////////
// tiled command encoder types
//////////////////////////////////////////////////////////////////////
`include "tiled_cmd_consts.svh"

package tiled_cmd_pkg;

    typedef logic [2:0]                          bank_t;
    typedef logic [`TILED_ADDRESS_NUMBER-1:0]    row_addr_t;
    typedef logic [`TILED_COLADDR_NUMBER-4:0]    col_burst_t;  // column in 8-word bursts
    typedef logic [`TILED_ADDRESS_NUMBER+`TILED_COLADDR_NUMBER-4:0] rowcol_t; // {row, col_burst}
    typedef logic [`TILED_FRAME_WIDTH_BITS:0]    rowcol_inc_t;
    typedef logic [5:0]                          tile_cnt_t;   // minus-one counts
    typedef logic [`TILED_CMD_PAUSE_BITS-1:0]    pause_t;
    typedef logic [`TILED_ADDRESS_NUMBER-1:0]    cmd_addr_t;
    typedef logic [31:0]                         cmd_word_t;   // {type, bank, addr, done, pause}

    // command type, bits 31:29 of a command word
    typedef enum logic [2:0] {
        nop       = 3'd0,
        buf_rst   = 3'd1, // reset external data buffer
        activate  = 3'd2,
        read      = 3'd3,
        write     = 3'd4,
        precharge = 3'd5
    } cmd_type_t;

endpackage

//--- tiled_cmd_consts.svh
//////////////////////////////////////////////////////////////////////
// tiled command encoder constants
//////////////////////////////////////////////////////////////////////
`ifndef TILED_CMD_CONSTS_SVH
`define TILED_CMD_CONSTS_SVH

`define TILED_ADDRESS_NUMBER   15 // row address bits
`define TILED_COLADDR_NUMBER   10 // column address bits, in words
`define TILED_CMD_PAUSE_BITS   10 // pause field of a command word
`define TILED_CMD_DONE_BIT     10 // done flag position
`define TILED_FRAME_WIDTH_BITS 13 // frame width in 8-word bursts

`define TILED_TRCD 4 // activate to read/write
`define TILED_TRP  4 // precharge to activate
`define TILED_TWR  6 // last write to precharge

`define TILED_SEQ_DEPTH_LOG2 6 // 64 command words

`endif
